/* verilog/gamePkg.sv */
package gamePkg;

    // board geometry
    localparam int numRows = 12;
    localparam int numCols = 10;
    localparam int spawnCol = 3;

    // cell and color widths
    localparam int kindW = 4;
    localparam int colorW = 8;
    localparam int numKinds = 9;

    // drop timing
    localparam int dropPeriod = 8;
    localparam int dropCntW = 3;

    // shape ROM geometry
    localparam int romAddrW = 6;
    localparam int romDepth = 64;

    // fetcher FSM encodings
    localparam logic [2:0] fetchIdle = 3'd0;
    localparam logic [2:0] fetchIndex = 3'd1;
    localparam logic [2:0] fetchBase = 3'd2;
    localparam logic [2:0] fetchRowsLo = 3'd3;
    localparam logic [2:0] fetchRowsHi = 3'd4;
    localparam logic [2:0] fetchLoad = 3'd5;

    // piece kinds, 0 is an empty cell
    localparam logic [kindW-1:0] kindNone = 4'd0;
    localparam logic [kindW-1:0] kindT = 4'd1;
    localparam logic [kindW-1:0] kindSquare = 4'd2;
    localparam logic [kindW-1:0] kindJ = 4'd3;
    localparam logic [kindW-1:0] kindL = 4'd4;
    localparam logic [kindW-1:0] kindZ = 4'd5;
    localparam logic [kindW-1:0] kindS = 4'd6;
    localparam logic [kindW-1:0] kindLine = 4'd7;
    localparam logic [kindW-1:0] kindCursed = 4'd8;

    // one ROM word, either an index entry or two shape rows
    typedef union packed {
        struct packed {
            logic [3:0] unused;
            logic [3:0] base;
        } index;
        struct packed {
            logic [3:0] upper;
            logic [3:0] lower;
        } shape;
    } romWordT;

    // column 0 is the leftmost element
    typedef logic [0:numCols-1][kindW-1:0] rowKindsT;

    localparam logic [colorW-1:0] palette [0:numKinds-1] = '{
        8'h00, 8'hE3, 8'hFC, 8'h03, 8'hF4, 8'hE0, 8'h1C, 8'h1F, 8'hB6
    };

endpackage

/* verilog/pieceLoadIf.sv */
`timescale 1ns/10ps

// one fetched piece, handed from the fetcher to the board
interface pieceLoadIf;

    // one-cycle strobe, kind and rows valid with it
    logic load;
    logic [gamePkg::kindW-1:0] kind;
    // row 0 is the top row, msb of each mask is the leftmost column
    logic [3:0][3:0] rows;

    modport source (
        output load,
        output kind,
        output rows
    );

    modport sink (
        input load,
        input kind,
        input rows
    );

endinterface

/* verilog/shapeRom.sv */
`timescale 1ns/10ps

module shapeRom (
    input  logic                         clk,
    input  logic [gamePkg::romAddrW-1:0] addr,
    output gamePkg::romWordT             data
);

    logic [7:0] romWord;

    always_comb begin
        case (addr)
            // index entries, shape lives at twice the base
            {2'b00, gamePkg::kindT}: romWord = 8'h08;
            {2'b00, gamePkg::kindSquare}: romWord = 8'h09;
            {2'b00, gamePkg::kindJ}: romWord = 8'h0A;
            {2'b00, gamePkg::kindL}: romWord = 8'h0B;
            {2'b00, gamePkg::kindZ}: romWord = 8'h0C;
            {2'b00, gamePkg::kindS}: romWord = 8'h0D;
            {2'b00, gamePkg::kindLine}: romWord = 8'h0E;
            {2'b00, gamePkg::kindCursed}: romWord = 8'h0F;
            // T
            6'd16: romWord = 8'hE4;
            6'd17: romWord = 8'h00;
            // square
            6'd18: romWord = 8'h66;
            6'd19: romWord = 8'h00;
            // J
            6'd20: romWord = 8'h8E;
            6'd21: romWord = 8'h00;
            // L
            6'd22: romWord = 8'h2E;
            6'd23: romWord = 8'h00;
            // Z
            6'd24: romWord = 8'hC6;
            6'd25: romWord = 8'h00;
            // S
            6'd26: romWord = 8'h6C;
            6'd27: romWord = 8'h00;
            // line
            6'd28: romWord = 8'hF0;
            6'd29: romWord = 8'h00;
            // cursed, uses both word pairs
            6'd30: romWord = 8'h96;
            6'd31: romWord = 8'h69;
            default: romWord = 8'h00;
        endcase
    end

    // synchronous read, data follows addr by one clock
    always_ff @(posedge clk) begin
        data <= romWord;
    end

    // the fetcher must never present an unknown or out-of-table address
    addrInRange: assert property (
        @(posedge clk) !$isunknown(addr) && (int'(addr) < gamePkg::romDepth)
    ) else $error("shapeRom addr out of range: %h", addr);

endmodule

/* verilog/pieceFetcher.sv */
`timescale 1ns/10ps

module pieceFetcher (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         newPiece,
    output logic [gamePkg::romAddrW-1:0] addr,
    input  gamePkg::romWordT             data,
    output logic                         busy,
    pieceLoadIf.source                   load
);

    logic [2:0] state;
    logic [gamePkg::kindW-1:0] pieceKind;
    logic [3:0] baseReg;
    logic [3:0][3:0] rowsReg;

    // address for the next ROM read, the ROM registers it
    always_comb begin
        case (state)
            gamePkg::fetchIndex: addr = {2'b00, pieceKind};
            // index word is on data now
            gamePkg::fetchBase: addr = {1'b0, data.index.base, 1'b0};
            gamePkg::fetchRowsLo: addr = {1'b0, baseReg, 1'b1};
            default: addr = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= gamePkg::fetchIdle;
            pieceKind <= gamePkg::kindLine;
        end else begin
            case (state)
                gamePkg::fetchIdle: begin
                    if (newPiece) begin
                        // kinds cycle 1..8
                        pieceKind <= (pieceKind % 4'd8) + 4'd1;
                        state <= gamePkg::fetchIndex;
                    end
                end
                gamePkg::fetchIndex: state <= gamePkg::fetchBase;
                gamePkg::fetchBase: state <= gamePkg::fetchRowsLo;
                gamePkg::fetchRowsLo: state <= gamePkg::fetchRowsHi;
                gamePkg::fetchRowsHi: state <= gamePkg::fetchLoad;
                default: state <= gamePkg::fetchIdle;
            endcase
        end
    end

    // payload capture, data is a shape word from here on
    always_ff @(posedge clk) begin
        if (state == gamePkg::fetchBase) begin
            baseReg <= data.index.base;
        end
        if (state == gamePkg::fetchRowsLo) begin
            rowsReg[0] <= data.shape.upper;
            rowsReg[1] <= data.shape.lower;
        end
        if (state == gamePkg::fetchRowsHi) begin
            rowsReg[2] <= data.shape.upper;
            rowsReg[3] <= data.shape.lower;
        end
    end

    assign busy = (state != gamePkg::fetchIdle);
    assign load.load = (state == gamePkg::fetchLoad);
    assign load.kind = pieceKind;
    assign load.rows = rowsReg;

    // a load is a single pulse inside a busy window
    loadPulse: assert property (
        @(posedge clk) disable iff (!rstN)
        load.load |-> busy ##1 !load.load
    ) else $error("load not a single pulse within busy");

endmodule

/* verilog/moveControl.sv */
`timescale 1ns/10ps

module moveControl (
    input  logic clk,
    input  logic rstN,
    input  logic moveLeft,
    input  logic moveRight,
    output logic tick,
    output logic pendLeft,
    output logic pendRight
);

    logic [1:0] leftSync;
    logic [1:0] rightSync;
    logic leftLast;
    logic rightLast;
    logic leftPress;
    logic rightPress;
    logic [gamePkg::dropCntW-1:0] dropCount;

    // two flops per button, then an edge detector
    always_ff @(posedge clk) begin
        if (!rstN) begin
            leftSync <= '0;
            rightSync <= '0;
            leftLast <= 1'b0;
            rightLast <= 1'b0;
        end else begin
            leftSync <= {leftSync[0], moveLeft};
            rightSync <= {rightSync[0], moveRight};
            leftLast <= leftSync[1];
            rightLast <= rightSync[1];
        end
    end

    assign leftPress = leftSync[1] & ~leftLast;
    assign rightPress = rightSync[1] & ~rightLast;

    // latest press wins, both cleared once a tick consumes them
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pendLeft <= 1'b0;
            pendRight <= 1'b0;
        end else if (tick) begin
            pendLeft <= 1'b0;
            pendRight <= 1'b0;
        end else if (leftPress && !rightPress) begin
            pendLeft <= 1'b1;
            pendRight <= 1'b0;
        end else if (rightPress && !leftPress) begin
            pendLeft <= 1'b0;
            pendRight <= 1'b1;
        end
    end

    // drop period counter
    always_ff @(posedge clk) begin
        if (!rstN) begin
            dropCount <= '0;
            tick <= 1'b0;
        end else begin
            dropCount <= dropCount + 1'b1;
            tick <= (dropCount == gamePkg::dropCntW'(gamePkg::dropPeriod - 1));
        end
    end

    pendExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(pendLeft && pendRight)
    ) else $error("pendLeft and pendRight both set");

endmodule

/* verilog/gameBoard.sv */
`timescale 1ns/10ps

module gameBoard (
    input  logic              clk,
    input  logic              rstN,
    pieceLoadIf.sink          load,
    input  logic              tick,
    input  logic              pendLeft,
    input  logic              pendRight,
    input  logic [3:0]        rowSel,
    output gamePkg::rowKindsT rowKinds,
    output logic              landed
);

    gamePkg::rowKindsT falling [gamePkg::numRows];
    gamePkg::rowKindsT stored [gamePkg::numRows];
    gamePkg::rowKindsT spawnLayer [gamePkg::numRows];
    gamePkg::rowKindsT movedLayer [gamePkg::numRows];

    logic [gamePkg::numRows-1:0][0:gamePkg::numCols-1] fallOcc;
    logic [gamePkg::numRows-1:0][0:gamePkg::numCols-1] storeOcc;
    logic landNow;
    logic canLeft;
    logic canRight;
    logic shiftLeft;
    logic shiftRight;
    logic hasPiece;

    // occupancy maps of both layers
    always_comb begin
        for (int r = 0; r < gamePkg::numRows; r++) begin
            for (int c = 0; c < gamePkg::numCols; c++) begin
                fallOcc[r][c] = (falling[r][c] != gamePkg::kindNone);
                storeOcc[r][c] = (stored[r][c] != gamePkg::kindNone);
            end
        end
    end

    assign hasPiece = |fallOcc;

    // rests on the floor or on a stored cell
    always_comb begin
        landNow = |fallOcc[gamePkg::numRows-1];
        for (int r = 0; r < gamePkg::numRows - 1; r++) begin
            landNow = landNow | (|(fallOcc[r] & storeOcc[r+1]));
        end
    end

    // shift legality, checked at the dropped and shifted position
    always_comb begin
        canLeft = 1'b1;
        canRight = 1'b1;
        for (int r = 0; r < gamePkg::numRows - 1; r++) begin
            for (int c = 0; c < gamePkg::numCols; c++) begin
                if (fallOcc[r][c]) begin
                    if (c == 0 || storeOcc[r+1][(c == 0) ? 0 : c-1]) begin
                        canLeft = 1'b0;
                    end
                    if (c == gamePkg::numCols - 1 ||
                        storeOcc[r+1][(c == gamePkg::numCols - 1) ? c : c+1]) begin
                        canRight = 1'b0;
                    end
                end
            end
        end
    end

    assign shiftLeft = pendLeft & canLeft;
    assign shiftRight = pendRight & canRight;

    // falling layer one row down, optionally one column over
    always_comb begin
        for (int r = 0; r < gamePkg::numRows; r++) begin
            movedLayer[r] = '0;
        end
        for (int r = 1; r < gamePkg::numRows; r++) begin
            for (int c = 0; c < gamePkg::numCols; c++) begin
                if (shiftLeft) begin
                    if (c < gamePkg::numCols - 1) begin
                        movedLayer[r][c] = falling[r-1][c+1];
                    end
                end else if (shiftRight) begin
                    if (c > 0) begin
                        movedLayer[r][c] = falling[r-1][c-1];
                    end
                end else begin
                    movedLayer[r][c] = falling[r-1][c];
                end
            end
        end
    end

    // new piece in rows 0-3 starting at the spawn column
    always_comb begin
        for (int r = 0; r < gamePkg::numRows; r++) begin
            spawnLayer[r] = '0;
        end
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 4; i++) begin
                if (load.rows[r][3-i]) begin
                    spawnLayer[r][gamePkg::spawnCol + i] = load.kind;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < gamePkg::numRows; r++) begin
                falling[r] <= '0;
                stored[r] <= '0;
            end
            landed <= 1'b0;
        end else begin
            landed <= 1'b0;
            if (load.load) begin
                falling <= spawnLayer;
            end else if (tick && hasPiece) begin
                if (landNow) begin
                    // merge into the stored layer
                    for (int r = 0; r < gamePkg::numRows; r++) begin
                        stored[r] <= stored[r] | falling[r];
                        falling[r] <= '0;
                    end
                    landed <= 1'b1;
                end else begin
                    falling <= movedLayer;
                end
            end
        end
    end

    // row readout, rows past the board read empty
    always_comb begin
        if (rowSel < 4'(gamePkg::numRows)) begin
            rowKinds = falling[rowSel] | stored[rowSel];
        end else begin
            rowKinds = '0;
        end
    end

    noOverlap: assert property (
        @(posedge clk) disable iff (!rstN) !(|(fallOcc & storeOcc))
    ) else $error("falling and stored layers overlap");

endmodule

/* verilog/colorMapper.sv */
`timescale 1ns/10ps

module colorMapper (
    input  gamePkg::rowKindsT                          rowKinds,
    output logic [gamePkg::numCols*gamePkg::colorW-1:0] rowColors
);

    logic [gamePkg::kindW-1:0] cellKind;

    // column 0 lands in the top byte
    always_comb begin
        rowColors = '0;
        cellKind = '0;
        for (int c = 0; c < gamePkg::numCols; c++) begin
            cellKind = rowKinds[c];
            if (int'(cellKind) < gamePkg::numKinds) begin
                rowColors[(gamePkg::numCols - 1 - c) * gamePkg::colorW +: gamePkg::colorW] =
                    gamePkg::palette[cellKind];
            end else begin
                // unknown kinds show as background
                rowColors[(gamePkg::numCols - 1 - c) * gamePkg::colorW +: gamePkg::colorW] =
                    '0;
            end
        end
    end

endmodule

/* verilog/gameTop.sv */
`timescale 1ns/10ps

module gameTop (
    input  logic                                        clk,
    input  logic                                        rstN,
    input  logic                                        newPiece,
    input  logic                                        moveLeft,
    input  logic                                        moveRight,
    input  logic [3:0]                                  rowSel,
    output logic [gamePkg::numCols*gamePkg::colorW-1:0] rowColors,
    output logic                                        landed,
    output logic                                        busy
);

    logic [gamePkg::romAddrW-1:0] romAddr;
    gamePkg::romWordT romData;
    logic tick;
    logic pendLeft;
    logic pendRight;
    gamePkg::rowKindsT rowKinds;

    pieceLoadIf pieceLoad_i ();

    shapeRom shapeRom_i (
        .clk  (clk),
        .addr (romAddr),
        .data (romData)
    );

    pieceFetcher pieceFetcher_i (
        .clk      (clk),
        .rstN     (rstN),
        .newPiece (newPiece),
        .addr     (romAddr),
        .data     (romData),
        .busy     (busy),
        .load     (pieceLoad_i.source)
    );

    moveControl moveControl_i (
        .clk       (clk),
        .rstN      (rstN),
        .moveLeft  (moveLeft),
        .moveRight (moveRight),
        .tick      (tick),
        .pendLeft  (pendLeft),
        .pendRight (pendRight)
    );

    gameBoard gameBoard_i (
        .clk       (clk),
        .rstN      (rstN),
        .load      (pieceLoad_i.sink),
        .tick      (tick),
        .pendLeft  (pendLeft),
        .pendRight (pendRight),
        .rowSel    (rowSel),
        .rowKinds  (rowKinds),
        .landed    (landed)
    );

    colorMapper colorMapper_i (
        .rowKinds  (rowKinds),
        .rowColors (rowColors)
    );

endmodule

/* tests/gameTopTb.sv */
`timescale 1ns/10ps

module gameTopTb;

    logic clk;
    logic rstN;
    logic newPiece;
    logic moveLeft;
    logic moveRight;
    logic [3:0] rowSel;
    logic [gamePkg::numCols*gamePkg::colorW-1:0] rowColors;
    logic landed;
    logic busy;

    int errCount;
    int checkCount;
    int edgeCnt;

    // board model, stored cells plus one falling piece
    logic [3:0] modelStored [gamePkg::numRows][gamePkg::numCols];
    logic [3:0] pieceMask [4];
    logic [3:0] pieceKind;
    int pieceRow;
    int pieceCol;

    gameTop gameTop_i (
        .clk       (clk),
        .rstN      (rstN),
        .newPiece  (newPiece),
        .moveLeft  (moveLeft),
        .moveRight (moveRight),
        .rowSel    (rowSel),
        .rowColors (rowColors),
        .landed    (landed),
        .busy      (busy)
    );

    always #10 clk = ~clk;

    // 4x4 shapes, top row in the high nibble, msb is the left column
    function automatic logic [3:0] shapeRow(input logic [3:0] kind, input int r);
        logic [15:0] rows;
        case (kind)
            gamePkg::kindT: rows = 16'hE400;
            gamePkg::kindSquare: rows = 16'h6600;
            gamePkg::kindJ: rows = 16'h8E00;
            gamePkg::kindL: rows = 16'h2E00;
            gamePkg::kindZ: rows = 16'hC600;
            gamePkg::kindS: rows = 16'h6C00;
            gamePkg::kindLine: rows = 16'hF000;
            gamePkg::kindCursed: rows = 16'h9669;
            default: rows = 16'h0000;
        endcase
        return rows[15-4*r -: 4];
    endfunction

    function automatic logic [3:0] pieceAt(input int r, input int c);
        if (pieceKind == gamePkg::kindNone) return gamePkg::kindNone;
        if (r < pieceRow || r > pieceRow + 3) return gamePkg::kindNone;
        if (c < pieceCol || c > pieceCol + 3) return gamePkg::kindNone;
        if (!pieceMask[r-pieceRow][3-(c-pieceCol)]) return gamePkg::kindNone;
        return pieceKind;
    endfunction

    // piece inside the board and clear of stored cells at this spot
    function automatic bit pieceFits(input int row, input int col);
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 4; i++) begin
                if (pieceMask[r][3-i]) begin
                    if (row + r >= gamePkg::numRows) return 1'b0;
                    if (col + i < 0 || col + i >= gamePkg::numCols) return 1'b0;
                    if (modelStored[row+r][col+i] != gamePkg::kindNone) return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    task automatic modelSpawn(input logic [3:0] kind);
        pieceKind = kind;
        pieceRow = 0;
        pieceCol = gamePkg::spawnCol;
        for (int r = 0; r < 4; r++) begin
            pieceMask[r] = shapeRow(kind, r);
        end
    endtask

    // one drop tick: land and merge, or shift if legal and move down
    task automatic modelTick(input int shift, output bit landNow);
        landNow = !pieceFits(pieceRow + 1, pieceCol);
        if (landNow) begin
            for (int r = 0; r < gamePkg::numRows; r++) begin
                for (int c = 0; c < gamePkg::numCols; c++) begin
                    if (pieceAt(r, c) != gamePkg::kindNone) begin
                        modelStored[r][c] = pieceAt(r, c);
                    end
                end
            end
            pieceKind = gamePkg::kindNone;
        end else begin
            if (shift != 0 && pieceFits(pieceRow + 1, pieceCol + shift)) begin
                pieceCol = pieceCol + shift;
            end
            pieceRow = pieceRow + 1;
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        if (rstN) begin
            edgeCnt++;
        end
        #2;
    endtask

    // ticks act on edges 9, 17, 25 ... after reset release
    task automatic waitTickEdge();
        int n;
        n = 0;
        while (edgeCnt % 8 != 1 && n < 16) begin
            stepCycle();
            n++;
        end
        tickSeen: assert (n < 16) else begin
            errCount++;
            $display("timed out waiting for a drop tick");
        end
    endtask

    task automatic checkBoard();
        logic [gamePkg::numCols*gamePkg::colorW-1:0] expRow;
        logic [3:0] kind;
        for (int r = 0; r < gamePkg::numRows; r++) begin
            expRow = '0;
            for (int c = 0; c < gamePkg::numCols; c++) begin
                kind = modelStored[r][c] | pieceAt(r, c);
                expRow[(gamePkg::numCols-1-c)*gamePkg::colorW +: gamePkg::colorW] =
                    gamePkg::palette[kind];
            end
            rowSel = 4'(r);
            #1;
            checkCount++;
            rowMatch: assert (rowColors === expRow) else begin
                errCount++;
                $display("CHECK FAILED rowColors row %0d: got %h expected %h",
                    r, rowColors, expRow);
            end
        end
    endtask

    task automatic resetDut();
        if (rstN) begin
            stepCycle();
        end
        rstN = 1'b0;
        repeat (10) stepCycle();
        rstN = 1'b1;
        edgeCnt = 0;
        for (int r = 0; r < gamePkg::numRows; r++) begin
            for (int c = 0; c < gamePkg::numCols; c++) begin
                modelStored[r][c] = gamePkg::kindNone;
            end
        end
        pieceKind = gamePkg::kindNone;
    endtask

    // strobe newPiece, optionally again while busy, and check load timing
    task automatic spawnPiece(input logic [3:0] kind, input bit extraStrobe);
        int n;
        stepCycle();
        newPiece = 1'b1;
        stepCycle();
        newPiece = extraStrobe;
        checkCount++;
        busyHigh: assert (busy === 1'b1) else begin
            errCount++;
            $display("CHECK FAILED busy: got %h expected %h", busy, 1'b1);
        end
        n = 0;
        while (busy && n < 20) begin
            stepCycle();
            newPiece = 1'b0;
            n++;
        end
        checkCount++;
        loadDelay: assert (n == 5) else begin
            errCount++;
            $display("CHECK FAILED busy fall cycles: got %h expected %h", n, 5);
        end
        modelSpawn(kind);
        checkBoard();
    endtask

    task automatic dropAndLand();
        bit done;
        int n;
        done = 1'b0;
        n = 0;
        while (!done && n < 20) begin
            modelTick(0, done);
            n++;
        end
        n = 0;
        while (!landed && n < 200) begin
            stepCycle();
            n++;
        end
        landSeen: assert (n < 200) else begin
            errCount++;
            $display("timed out waiting for landed");
        end
        checkBoard();
        // landed is a single-cycle pulse
        stepCycle();
        checkCount++;
        landedPulse: assert (landed === 1'b0) else begin
            errCount++;
            $display("CHECK FAILED landed: got %h expected %h", landed, 1'b0);
        end
    endtask

    // one press per tick, right once, then left into the wall
    task automatic movePiece();
        int dirs [$];
        int gap;
        bit done;
        dirs = '{1, -1, -1, -1, -1, -1, -1};
        stepCycle();
        waitTickEdge();
        modelTick(0, done);
        foreach (dirs[k]) begin
            checkBoard();
            gap = int'($urandom % 4);
            repeat (gap) stepCycle();
            if (dirs[k] > 0) begin
                moveRight = 1'b1;
            end else begin
                moveLeft = 1'b1;
            end
            stepCycle();
            moveRight = 1'b0;
            moveLeft = 1'b0;
            waitTickEdge();
            modelTick(dirs[k], done);
        end
        checkBoard();
        dropAndLand();
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        newPiece = 1'b0;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        rowSel = 4'd0;
        errCount = 0;
        checkCount = 0;
        edgeCnt = 0;
        void'($urandom(87717));
        resetDut();

        checkCount++;
        idleAfterReset: assert (busy === 1'b0 && landed === 1'b0) else begin
            errCount++;
            $display("CHECK FAILED busy/landed: got %h/%h expected 0/0", busy, landed);
        end
        checkBoard();

        spawnPiece(gamePkg::kindCursed, 1'b0);
        dropAndLand();

        // each piece stacks on the previous ones
        spawnPiece(gamePkg::kindT, 1'b0);
        dropAndLand();
        spawnPiece(gamePkg::kindSquare, 1'b0);
        dropAndLand();
        spawnPiece(gamePkg::kindJ, 1'b0);
        dropAndLand();
        spawnPiece(gamePkg::kindL, 1'b0);
        dropAndLand();

        // fresh board for the moves, kinds restart at cursed
        resetDut();
        spawnPiece(gamePkg::kindCursed, 1'b0);
        movePiece();

        // strobe while busy must not skip a kind
        spawnPiece(gamePkg::kindT, 1'b1);
        dropAndLand();
        spawnPiece(gamePkg::kindSquare, 1'b0);

        $display("errors: %0d, checks: %0d", errCount, checkCount);
        if (errCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
verilog/gamePkg.sv
verilog/pieceLoadIf.sv
verilog/shapeRom.sv
verilog/pieceFetcher.sv
verilog/moveControl.sv
verilog/gameBoard.sv
verilog/colorMapper.sv
verilog/gameTop.sv
tests/gameTopTb.sv

/* Makefile */
sim:
	rm -f sim.log
	verilator --binary --timing --assert -f flist.f --top-module gameTopTb -o gameTopTb
	./obj_dir/gameTopTb | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
